// File: source/cachePkg.sv
/*
  Shared definitions for the read-only cache
  Cache geometry, address split and memory beat sizes
  State type of the cache controller FSM
*/

package cachePkg;

  ////////////////////////////////////////////////////////////
  // Geometry
  ////////////////////////////////////////////////////////////

  // Byte address width seen by the core and by memory
  localparam int AddrBits = 16;
  // One cache line holds 16 bytes
  localparam int LineBits = 128;
  // Width of the result handed back to the core
  localparam int WordBits = 32;
  // Results can start on any halfword inside the line
  localparam int MuxInterval = 16;

  // Memory returns a line as a burst of word-wide beats
  localparam int BeatBits = 32;
  localparam int BeatsPerLine = 4;

  // Address split is tag, then index, then byte offset
  localparam int OffsetBits = 4;
  localparam int IndexBits = 4;
  localparam int TagBits = 8;

  // Number of selectable start positions inside a line
  localparam int WordsPerLine = LineBits / MuxInterval;

  ////////////////////////////////////////////////////////////
  // Controller states
  ////////////////////////////////////////////////////////////

  // Answer is the cycle after a hit, and it lasts while the core stalls
  typedef enum logic [2:0] {
    idle,
    lookup,
    request,
    fill,
    answer
  } ctrlState_t;

endpackage

// File: source/lineWordSelect.sv
/*
  Word select for the cache read path
  Cuts a result word out of a line at a halfword offset
  Zero pads a word that runs past the line end
  Save and restore register that holds the word during a stall
*/

`timescale 1ns/1ps

module lineWordSelect (
  input  logic                          clk,
  input  logic [cachePkg::AddrBits-1:0] adr,
  input  logic [cachePkg::LineBits-1:0] lineData,
  input  logic                          save,
  input  logic                          restore,
  output logic [cachePkg::WordBits-1:0] wordData
);

  import cachePkg::*;

  // Line extended with zeros so the top candidate is a full word wide
  logic [LineBits+WordBits-MuxInterval-1:0] paddedLine;
  // One candidate word per halfword position
  logic [WordBits-1:0] candidates [WordsPerLine];
  logic [WordBits-1:0] rawWord;
  logic [WordBits-1:0] savedWord;

  // Upper bits past the line end read as zero
  assign paddedLine = {{(WordBits - MuxInterval){1'b0}}, lineData};

  // Each candidate starts one halfword above the previous one
  for (genvar i = 0; i < WordsPerLine; i++) begin : genCandidates
    assign candidates[i] = paddedLine[i*MuxInterval +: WordBits];
  end

  ////////////////////////////////////////////////////////////
  // Offset mux
  ////////////////////////////////////////////////////////////

  // Byte offset bits above the halfword boundary pick the candidate
  // Bit 0 of the address is ignored since requests are halfword aligned
  assign rawWord = candidates[adr[OffsetBits-1:$clog2(MuxInterval/8)]];

  ////////////////////////////////////////////////////////////
  // Stall hold
  ////////////////////////////////////////////////////////////

  // Capture the answered word in the readValid cycle of a stalled read
  always_ff @(posedge clk) begin
    if (save) begin
      savedWord <= rawWord;
    end
  end

  // While the core is stalled the live path may change with adr
  // so the output follows the captured copy
  assign wordData = restore ? savedWord : rawWord;

endmodule

// File: source/lineArray.sv
/*
  Direct-mapped line storage with 16 sets
  Valid bits, tags and line data
  Combinational read and hit compare, line write on the clock edge
*/

`timescale 1ns/1ps

module lineArray (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic [cachePkg::AddrBits-1:0] adr,
  input  logic                          fillWrite,
  input  logic [cachePkg::LineBits-1:0] fillLine,
  output logic [cachePkg::LineBits-1:0] lineData,
  output logic                          hit
);

  import cachePkg::*;

  // Set index and tag fields cut from the live address
  logic [IndexBits-1:0] setIndex;
  logic [TagBits-1:0]   adrTag;

  // Per-set state
  logic [2**IndexBits-1:0] validBits;
  logic [TagBits-1:0]      tagMem  [2**IndexBits];
  logic [LineBits-1:0]     lineMem [2**IndexBits];

  assign setIndex = adr[OffsetBits +: IndexBits];
  assign adrTag   = adr[AddrBits-1 -: TagBits];

  ////////////////////////////////////////////////////////////
  // Read side
  ////////////////////////////////////////////////////////////

  // Lookup is purely combinational so a hit answers in the lookup cycle
  assign lineData = lineMem[setIndex];

  // A set only hits once it has been filled and its tag matches
  assign hit = validBits[setIndex] && (tagMem[setIndex] == adrTag);

  ////////////////////////////////////////////////////////////
  // Write side
  ////////////////////////////////////////////////////////////

  // Valid bits are control state and start out clear
  always_ff @(posedge clk) begin
    if (!rstN) begin
      validBits <= '0;
    end else if (fillWrite) begin
      validBits[setIndex] <= 1'b1;
    end
  end

  // Tag and line are written together with the valid bit
  // A fill into a set that already holds another tag replaces that line
  always_ff @(posedge clk) begin
    if (fillWrite) begin
      tagMem[setIndex]  <= adrTag;
      lineMem[setIndex] <= fillLine;
    end
  end

endmodule

// File: source/lineFill.sv
/*
  Line fill collector
  Gathers memory beats into one cache line, lowest beat first
  Flags the last beat so the line can be written in that cycle
*/

`timescale 1ns/1ps

module lineFill (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic                          fillStart,
  input  logic                          memBeatValid,
  input  logic [cachePkg::BeatBits-1:0] memBeatData,
  output logic [cachePkg::LineBits-1:0] fillLine,
  output logic                          fillDone
);

  import cachePkg::*;

  // Position of the next beat inside the line
  logic [$clog2(BeatsPerLine)-1:0] beatCount;
  // Only the earlier beats are stored, the last one is used as it arrives
  logic [BeatBits-1:0] beatReg [BeatsPerLine-1];

  // The beat arriving now completes the line
  assign fillDone = memBeatValid && (int'(beatCount) == BeatsPerLine - 1);

  // Counter is cleared by each new miss request and wraps after the last beat
  always_ff @(posedge clk) begin
    if (!rstN) begin
      beatCount <= '0;
    end else if (fillStart) begin
      beatCount <= '0;
    end else if (memBeatValid) begin
      beatCount <= beatCount + 1'b1;
    end
  end

  // Beat storage for all but the final beat
  always_ff @(posedge clk) begin
    if (memBeatValid && !fillDone) begin
      beatReg[beatCount] <= memBeatData;
    end
  end

  // Stored beats form the low part of the line
  // and the arriving beat goes straight into the top slot
  always_comb begin
    for (int i = 0; i < BeatsPerLine - 1; i++) begin
      fillLine[i*BeatBits +: BeatBits] = beatReg[i];
    end
    fillLine[LineBits-1 -: BeatBits] = memBeatData;
  end

endmodule

// File: source/cacheController.sv
/*
  Cache controller FSM
  Runs lookup, miss request, line fill and answer
  Drives busy, readValid, the memory request and the fill strobes
  Produces save and restore for the stall hold register
*/

`timescale 1ns/1ps

module cacheController (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic                          readReq,
  input  logic                          stall,
  input  logic                          hit,
  input  logic                          fillDone,
  input  logic [cachePkg::AddrBits-1:0] adr,
  output logic                          busy,
  output logic                          readValid,
  output logic                          memReq,
  output logic [cachePkg::AddrBits-1:0] memAdr,
  output logic                          fillStart,
  output logic                          fillWrite,
  output logic                          save,
  output logic                          restore
);

  import cachePkg::*;

  ctrlState_t state;
  ctrlState_t nextState;

  // Set when an answer was saved and kept while the core stalls
  logic restoreFlag;

  ////////////////////////////////////////////////////////////
  // State register and next state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= idle;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      // Accept a new read, adr is held by the core from here on
      idle: begin
        if (readReq) begin
          nextState = lookup;
        end
      end
      // Hit answers now, a miss goes out to memory
      lookup: begin
        nextState = hit ? answer : request;
      end
      // One cycle for the memory request pulse
      request: begin
        nextState = fill;
      end
      // Wait for the last beat, then look up again so the new line hits
      fill: begin
        if (fillDone) begin
          nextState = lookup;
        end
      end
      // Busy is already low here, so a new read may start at once
      answer: begin
        if (readReq) begin
          nextState = lookup;
        end else if (!stall) begin
          nextState = idle;
        end
      end
      default: begin
        nextState = idle;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  // Busy covers the cycle after readReq through the readValid cycle
  assign busy = (state == lookup) || (state == request) || (state == fill);

  // The answer leaves in the lookup cycle that hits
  assign readValid = (state == lookup) && hit;

  // Memory request and fill counter clear go out together
  assign memReq    = (state == request);
  assign fillStart = (state == request);
  // Requests are always for a whole line
  assign memAdr    = {adr[AddrBits-1:OffsetBits], {OffsetBits{1'b0}}};

  // The last beat writes the line into the array
  assign fillWrite = (state == fill) && fillDone;

  // Capture the word only when the core is stalled as it is answered
  assign save = readValid && stall;

  // Flag stays set from the save until stall drops
  always_ff @(posedge clk) begin
    if (!rstN) begin
      restoreFlag <= 1'b0;
    end else begin
      restoreFlag <= save || (restoreFlag && stall);
    end
  end

  // Once stall drops the core sees the live path again
  assign restore = restoreFlag && stall;

endmodule

// File: source/readCache.sv
/*
  Top level of the read-only direct-mapped cache
  Connects controller, line array, fill collector and word select
*/

`timescale 1ns/1ps

module readCache (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic                          readReq,
  input  logic [cachePkg::AddrBits-1:0] adr,
  input  logic                          stall,
  output logic                          busy,
  output logic                          readValid,
  output logic [cachePkg::WordBits-1:0] readData,
  output logic                          memReq,
  output logic [cachePkg::AddrBits-1:0] memAdr,
  input  logic                          memBeatValid,
  input  logic [cachePkg::BeatBits-1:0] memBeatData
);

  import cachePkg::*;

  // Controller handshakes with the datapath blocks
  logic hit;
  logic fillStart;
  logic fillDone;
  logic fillWrite;
  logic save;
  logic restore;

  // Line buses between fill, array and word select
  logic [LineBits-1:0] fillLine;
  logic [LineBits-1:0] lineData;

  cacheController cacheCtrl (
    .clk       (clk),
    .rstN      (rstN),
    .readReq   (readReq),
    .stall     (stall),
    .hit       (hit),
    .fillDone  (fillDone),
    .adr       (adr),
    .busy      (busy),
    .readValid (readValid),
    .memReq    (memReq),
    .memAdr    (memAdr),
    .fillStart (fillStart),
    .fillWrite (fillWrite),
    .save      (save),
    .restore   (restore)
  );

  // Array and word select both work on the live address
  lineArray lineArr (
    .clk       (clk),
    .rstN      (rstN),
    .adr       (adr),
    .fillWrite (fillWrite),
    .fillLine  (fillLine),
    .lineData  (lineData),
    .hit       (hit)
  );

  lineFill fillUnit (
    .clk          (clk),
    .rstN         (rstN),
    .fillStart    (fillStart),
    .memBeatValid (memBeatValid),
    .memBeatData  (memBeatData),
    .fillLine     (fillLine),
    .fillDone     (fillDone)
  );

  lineWordSelect wordSel (
    .clk      (clk),
    .adr      (adr),
    .lineData (lineData),
    .save     (save),
    .restore  (restore),
    .wordData (readData)
  );

endmodule

// File: tb/readCache_asserts.sv
/*
  Concurrent assertions on the cache controller outputs
  Failure counter that the testbench reads at the end of the run
  Bind of the checker into every cacheController instance
*/

`timescale 1ns/1ps

module readCache_asserts (
  input logic clk,
  input logic rstN,
  input logic busy,
  input logic readValid,
  input logic memReq,
  input logic save,
  input logic restore
);

  // Number of assertion failures seen so far
  int failCount = 0;

  // A read is answered from the array or sent to memory, never both in one cycle
  noReqWithAnswer: assert property (
    @(posedge clk) disable iff (!rstN) !(memReq && readValid)
  ) else begin
    failCount++;
    $error("memReq and readValid high in the same cycle");
  end

  // Restore only continues a hold that a save started
  restoreAfterSave: assert property (
    @(posedge clk) disable iff (!rstN) restore |-> $past(save || restore)
  ) else begin
    failCount++;
    $error("restore high without save or restore in the cycle before");
  end

  // Synchronous reset parks the FSM in idle
  idleAfterReset: assert property (
    @(posedge clk) !rstN |=> !busy
  ) else begin
    failCount++;
    $error("busy high in the cycle after a reset edge");
  end

endmodule

bind cacheController readCache_asserts ctrlAsserts (
  .clk       (clk),
  .rstN      (rstN),
  .busy      (busy),
  .readValid (readValid),
  .memReq    (memReq),
  .save      (save),
  .restore   (restore)
);

// File: tb/readCacheTb.sv
/*
  Testbench for the read-only direct-mapped cache
  Clock, reset and a halfword memory model with random beat gaps
  Reference tag table that predicts hits and misses
  Directed reads for reset, hit, replace and line end, then random reads with stalls
*/

`timescale 1ns/1ps

module readCacheTb;

  import cachePkg::*;

  localparam int Seed        = 32'h1eb9;
  localparam int Period      = 100;
  localparam int ResetCycles = 8;
  localparam int NumReads    = 200;
  localparam int ReadTimeout = 64;

  logic                clk;
  logic                rstN;
  logic                readReq;
  logic [AddrBits-1:0] adr;
  logic                stall;
  logic                busy;
  logic                readValid;
  logic [WordBits-1:0] readData;
  logic                memReq;
  logic [AddrBits-1:0] memAdr;
  logic                memBeatValid;
  logic [BeatBits-1:0] memBeatData;

  // Request stream and beat timing draw from separate seed variables
  int    seed;
  int    beatSeed;
  string testName;

  // Backing memory with one entry per halfword of the address space
  logic [15:0] memTable [2**(AddrBits-1)];

  // Reference valid bits and tags
  logic [2**IndexBits-1:0] modelValid;
  logic [TagBits-1:0]      modelTag [2**IndexBits];

  initial begin
    clk = 1'b0;
    forever begin
      #(Period / 2) clk = ~clk;
    end
  end

  readCache readCache_inst (
    .clk          (clk),
    .rstN         (rstN),
    .readReq      (readReq),
    .adr          (adr),
    .stall        (stall),
    .busy         (busy),
    .readValid    (readValid),
    .readData     (readData),
    .memReq       (memReq),
    .memAdr       (memAdr),
    .memBeatValid (memBeatValid),
    .memBeatData  (memBeatData)
  );

  ////////////////////////////////////////////////////////////
  // Error reporting
  ////////////////////////////////////////////////////////////

  task automatic reportMismatch(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
    $display("Fail %s (%s): expected %h, actual %h", testName, what, expected, actual);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic reportError(input string msg);
    $display("Error in %s: %s", testName, msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  ////////////////////////////////////////////////////////////
  // Reference values
  ////////////////////////////////////////////////////////////

  // Two halfwords from the byte address, the upper one zero past the line end
  function automatic logic [31:0] expectedWord(input logic [15:0] a);
    logic [14:0] hw;
    logic [15:0] hi;
    hw = a[15:1];
    if (a[3:1] == 3'b111) begin
      hi = 16'h0000;
    end else begin
      hi = memTable[hw + 15'd1];
    end
    return {hi, memTable[hw]};
  endfunction

  // Beat n of a line carries halfwords 2n and 2n+1, lower one in the low bits
  function automatic logic [31:0] beatWord(input logic [15:0] lineAdr, input logic [1:0] n);
    return {memTable[{lineAdr[15:4], n, 1'b1}], memTable[{lineAdr[15:4], n, 1'b0}]};
  endfunction

  // Mostly two tags per set, so hits and replacements both happen often
  function automatic logic [15:0] randomAddress();
    logic [31:0] r;
    logic [7:0]  tag;
    r = $random(seed);
    if (r[17:16] == 2'b00) begin
      tag = r[31:24];
    end else begin
      tag = {7'h35, r[18]};
    end
    return {tag, r[7:4], r[3:1], 1'b0};
  endfunction

  ////////////////////////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////////////////////////

  initial begin : memoryModel
    logic [15:0] lineAdr;
    logic [31:0] r;
    int gap;
    beatSeed = Seed;
    memBeatValid = 1'b0;
    memBeatData = '0;
    forever begin
      @(negedge clk);
      if (memReq) begin
        lineAdr = memAdr;
        // First beat comes one or more cycles after the request cycle
        for (int b = 0; b < BeatsPerLine; b++) begin
          r = $random(beatSeed);
          gap = int'(r[1:0]);
          @(negedge clk);
          memBeatValid = 1'b0;
          repeat (gap) @(negedge clk);
          memBeatValid = 1'b1;
          memBeatData = beatWord(lineAdr, 2'(b));
        end
        @(negedge clk);
        memBeatValid = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Read sequence
  ////////////////////////////////////////////////////////////

  // One read from request to answer, with an optional stall hold afterwards
  task automatic performRead(input logic [15:0] a, input logic holdStall,
                             output logic [31:0] data, output int latency,
                             output int reqCount);
    logic [IndexBits-1:0] idx;
    logic [TagBits-1:0]   tag;
    logic                 expHit;
    logic [31:0]          expWord;
    logic [15:0]          lineAdr;
    logic                 gotValid;
    logic [31:0]          r;
    int                   holdCycles;
    idx = a[OffsetBits +: IndexBits];
    tag = a[AddrBits-1 -: TagBits];
    expHit = modelValid[idx] && (modelTag[idx] == tag);
    expWord = expectedWord(a);
    lineAdr = {a[15:4], 4'h0};
    data = '0;
    latency = 0;
    reqCount = 0;
    gotValid = 1'b0;
    @(negedge clk);
    assert (!busy && !readValid) else reportError("cache not idle before a new read");
    readReq = 1'b1;
    adr = a;
    while (!gotValid) begin
      @(negedge clk);
      latency++;
      assert (busy) else reportError("busy low while a read is in flight");
      if (memReq) begin
        reqCount++;
        assert (memAdr == lineAdr) else reportMismatch("memAdr", 32'(lineAdr), 32'(memAdr));
      end
      if (readValid) begin
        gotValid = 1'b1;
        data = readData;
      end
      readReq = 1'b0;
      // Stall rises once the request is taken, still ahead of the answer edge
      stall = holdStall;
      assert (latency < ReadTimeout) else reportError("timed out waiting for readValid");
    end
    assert (data == expWord) else reportMismatch("readData", expWord, data);
    if (expHit) begin
      assert (latency == 1) else reportMismatch("hit latency", 1, latency);
      assert (reqCount == 0) else reportMismatch("memReq count on hit", 0, reqCount);
    end else begin
      assert (reqCount == 1) else reportMismatch("memReq count on miss", 1, reqCount);
    end
    modelValid[idx] = 1'b1;
    modelTag[idx] = tag;
    if (holdStall) begin
      r = $random(seed);
      // At least one checked cycle comes after the address has moved
      holdCycles = 2 + int'(r[1:0]);
      // Address wanders during the stall but the answer must not move
      for (int k = 0; k < holdCycles; k++) begin
        @(negedge clk);
        assert (!readValid && !busy) else reportError("cache active during a stall");
        assert (readData == expWord) else reportMismatch("stalled readData", expWord, readData);
        r = $random(seed);
        adr = {r[15:1], 1'b0};
      end
      stall = 1'b0;
    end else begin
      @(negedge clk);
      assert (!readValid) else reportError("readValid longer than one cycle");
    end
  endtask

  task automatic checkLineEnd(input logic [15:0] a);
    logic [31:0] data;
    int          latency;
    int          reqCount;
    performRead(a, 1'b0, data, latency, reqCount);
    assert (data[31:16] == 16'h0000) else reportMismatch("upper half", 0, 32'(data[31:16]));
    assert (data[15:0] == memTable[a[15:1]])
      else reportMismatch("lower half", 32'(memTable[a[15:1]]), 32'(data[15:0]));
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin : mainFlow
    logic [31:0] r;
    logic [31:0] data;
    int          latency;
    int          reqCount;
    seed = Seed;
    rstN = 1'b0;
    readReq = 1'b0;
    adr = '0;
    stall = 1'b0;
    modelValid = '0;
    for (int i = 0; i < 2**(AddrBits-1); i++) begin
      r = $random(seed);
      memTable[i] = r[15:0];
    end

    testName = "reset";
    for (int i = 0; i < ResetCycles; i++) begin
      @(negedge clk);
      assert (!busy && !readValid && !memReq) else reportError("outputs active in reset");
    end
    rstN = 1'b1;
    @(negedge clk);
    assert (!busy && !readValid && !memReq) else reportError("outputs active after reset");

    testName = "first miss";
    performRead(16'h1230, 1'b0, data, latency, reqCount);
    assert (reqCount == 1) else reportMismatch("memReq count", 1, reqCount);

    testName = "hit";
    performRead(16'h1232, 1'b0, data, latency, reqCount);
    assert (latency == 1) else reportMismatch("latency", 1, latency);
    assert (reqCount == 0) else reportMismatch("memReq count", 0, reqCount);

    // Same set, other tag, then back to the first tag
    testName = "replace";
    performRead(16'h5630, 1'b0, data, latency, reqCount);
    assert (reqCount == 1) else reportMismatch("memReq count new tag", 1, reqCount);
    performRead(16'h1234, 1'b0, data, latency, reqCount);
    assert (reqCount == 1) else reportMismatch("memReq count old tag", 1, reqCount);

    testName = "line end";
    checkLineEnd(16'h123e);
    checkLineEnd(16'h9afe);

    testName = "stall hold";
    performRead(16'h4a16, 1'b1, data, latency, reqCount);
    performRead(16'h4a1a, 1'b1, data, latency, reqCount);

    testName = "random";
    for (int n = 0; n < NumReads; n++) begin
      r = $random(seed);
      performRead(randomAddress(), r[1:0] == 2'b00, data, latency, reqCount);
      for (int k = 0; k < int'(r[3:2]); k++) begin
        @(negedge clk);
        assert (!busy && !memReq) else reportError("cache active between reads");
      end
    end

    testName = "end of run";
    if (readCache_inst.cacheCtrl.ctrlAsserts.failCount == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("Controller assertions failed %0d times",
               readCache_inst.cacheCtrl.ctrlAsserts.failCount);
      $display("Checks failed");
      $fatal(1);
    end
  end

endmodule

// File: src.f
source/cachePkg.sv
source/lineWordSelect.sv
source/lineArray.sv
source/lineFill.sv
source/cacheController.sv
source/readCache.sv
tb/readCache_asserts.sv
tb/readCacheTb.sv

// File: Makefile
# Verilator build and run for the read cache testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := readCacheTb
FILELIST  := src.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation PASSED"; \
	else \
		echo "Simulation FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
